// ==== Makefile ====
# Verilator build and run of the instruction cache testbench

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = icache_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = sim passed
RUN_OPTS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the result is taken from the log, not from the exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_OPTS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/icache_checker.sv ====
// protocol and state assertions for the instruction cache
// Wishbone strobe inside a cycle, at most one hitting way,
// no bus cycle during the flush sweep
// bound into every icache_top instance

`timescale 1ns/1ps
`default_nettype none

module icache_checker (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic [icache_pkg::NUM_WAYS-1:0]   hit_way_i,
  input  icache_pkg::ctrl_state_e           state_i
);

  // number of failed assertions, read by the testbench top
  int unsigned fail_cnt = 0;

  stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_i |-> wb_cyc_i)
    else begin
      fail_cnt++;
      $error("wishbone strobe outside a bus cycle");
    end

  // a line lives in one way only
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_way_i))
    else begin
      fail_cnt++;
      $error("more than one way hits");
    end

  no_bus_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == icache_pkg::FLUSH) |-> !wb_cyc_i)
    else begin
      fail_cnt++;
      $error("bus cycle during the flush sweep");
    end

endmodule

bind icache_top icache_checker icache_checker_inst (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .wb_cyc_i  (wb_cyc_o),
  .wb_stb_i  (wb_stb_o),
  .hit_way_i (icache_ways_inst.hit_way),
  .state_i   (icache_ctrl_inst.state_q)
);

`default_nettype wire

// ==== bench/icache_tb.sv ====
// testbench top of the instruction cache
// stimulus table of fetches applied in a loop
// response, miss pulse and Wishbone address checks
// cycle-count timeout and the closing result lines

`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  logic        clk;
  logic        rst_n;
  logic        en;
  logic        flush;
  logic        req;
  logic [31:0] addr;
  logic        ready;
  logic        valid;
  logic [31:0] data;
  logic        miss;
  logic        wb_cyc;
  logic        wb_stb;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat;
  logic        wb_ack;

  // stimulus table, one entry per fetch
  string       row_name  [$];
  logic [31:0] row_addr  [$];
  bit          row_en    [$];
  bit          row_flush [$];
  // bus reads expected, -1 when a hit and a miss are both correct
  int          row_reads [$];

  // addresses of acked bus reads in the current fetch
  logic [31:0] wb_adrs [$];
  int unsigned err_cnt   = 0;
  int unsigned check_cnt = 0;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit;

  tb_clkgen tb_clkgen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  wb_mem_model wb_mem_model_inst (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .cyc_i  (wb_cyc),
    .stb_i  (wb_stb),
    .adr_i  (wb_adr),
    .dat_o  (wb_dat),
    .ack_o  (wb_ack)
  );

  icache_top icache_top_inst (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .en_i     (en),
    .flush_i  (flush),
    .req_i    (req),
    .addr_i   (addr),
    .ready_o  (ready),
    .valid_o  (valid),
    .data_o   (data),
    .miss_o   (miss),
    .wb_cyc_o (wb_cyc),
    .wb_stb_o (wb_stb),
    .wb_adr_o (wb_adr),
    .wb_dat_i (wb_dat),
    .wb_ack_i (wb_ack)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // memory contents, word address xor fixed pattern
  function automatic logic [31:0] expected_word(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  task automatic add_row(input string name, input logic [31:0] a, input bit e,
                         input bit f, input int reads);
    row_name.push_back(name);
    row_addr.push_back(a);
    row_en.push_back(e);
    row_flush.push_back(f);
    row_reads.push_back(reads);
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("FAIL %s %s: expected 0x%08h, actual 0x%08h", name, what, exp, act);
    end
  endtask

  task automatic print_counts();
    $display("checks %0d, errors %0d, assertion failures %0d", check_cnt, err_cnt,
             icache_top_inst.icache_checker_inst.fail_cnt);
  endtask

  task automatic load_table();
    add_row("cold_miss",    32'h0000_1004, 1'b1, 1'b0, 4);
    add_row("hit_w0",       32'h0000_1000, 1'b1, 1'b0, 0);
    add_row("hit_w2",       32'h0000_1008, 1'b1, 1'b0, 0);
    add_row("hit_w3",       32'h0000_100C, 1'b1, 1'b0, 0);
    // three lines sharing index 3
    add_row("conf_a_miss",  32'h0000_2030, 1'b1, 1'b0, 4);
    add_row("conf_b_miss",  32'h0000_3034, 1'b1, 1'b0, 4);
    add_row("conf_a_hit",   32'h0000_2030, 1'b1, 1'b0, 0);
    add_row("conf_b_hit",   32'h0000_303C, 1'b1, 1'b0, 0);
    add_row("conf_c_miss",  32'h0000_4038, 1'b1, 1'b0, 4);
    add_row("conf_a_again", 32'h0000_2034, 1'b1, 1'b0, -1);
    add_row("conf_b_again", 32'h0000_3030, 1'b1, 1'b0, -1);
    add_row("pre_flush",    32'h0000_1008, 1'b1, 1'b0, 0);
    add_row("flush_miss",   32'h0000_1008, 1'b1, 1'b1, 4);
    add_row("flush_rehit",  32'h0000_1000, 1'b1, 1'b0, 0);
    // cache disabled, every fetch goes to the bus
    add_row("unc_a",        32'h0000_1004, 1'b0, 1'b0, 1);
    add_row("unc_a_repeat", 32'h0000_1004, 1'b0, 1'b0, 1);
    add_row("unc_b",        32'h0000_5678, 1'b0, 1'b0, 1);
    // enabling again sweeps the arrays first
    add_row("reenable",     32'h0000_1004, 1'b1, 1'b0, 4);
    add_row("reenable_hit", 32'h0000_100C, 1'b1, 1'b0, 0);
  endtask

  ////////////////////////////////////////
  // one fetch from the table
  ////////////////////////////////////////

  task automatic run_row(input int idx);
    logic [31:0] got;
    logic [31:0] exp_adr;
    int          misses;
    int          reads;
    int          exp_reads;
    wb_adrs.delete();
    @(posedge clk);
    en    <= row_en[idx];
    flush <= row_flush[idx];
    // request goes out only after the flush pulse was sampled
    @(posedge clk);
    flush <= 1'b0;
    req   <= 1'b1;
    addr  <= row_addr[idx];
    @(negedge clk);
    while (!ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    req <= 1'b0;
    misses = 0;
    @(negedge clk);
    while (!valid) begin
      if (miss) begin
        misses++;
      end
      @(negedge clk);
    end
    // a miss pulse together with valid_o counts as well
    if (miss) begin
      misses++;
    end
    got = data;
    check_value(row_name[idx], "data", expected_word(row_addr[idx]), got);
    reads     = wb_adrs.size();
    exp_reads = row_reads[idx];
    if (exp_reads < 0) begin
      // either a hit or a full line refill
      if (reads != 0 && reads != 4) begin
        err_cnt++;
        $display("%s made %0d bus reads, neither a hit nor a line refill",
                 row_name[idx], reads);
      end
      exp_reads = reads;
    end else begin
      check_value(row_name[idx], "bus reads", exp_reads, reads);
    end
    // a miss pulse goes with every refill and only with a refill
    check_value(row_name[idx], "miss pulses", (exp_reads == 4) ? 1 : 0, misses);
    if (reads == exp_reads) begin
      for (int k = 0; k < reads; k++) begin
        if (exp_reads == 4) begin
          exp_adr = {row_addr[idx][31:4], 4'h0} + 32'(4 * k);
        end else begin
          exp_adr = {row_addr[idx][31:2], 2'b00};
        end
        check_value(row_name[idx], "bus address", exp_adr, wb_adrs[k]);
      end
    end
  endtask

  ////////////////////////////////////////
  // bus monitor and timeout
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (wb_cyc && wb_stb && wb_ack) begin
      wb_adrs.push_back(wb_adr);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      print_counts();
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int unsigned low_cycles;
    en    = 1'b1;
    flush = 1'b0;
    req   = 1'b0;
    addr  = '0;
    load_table();
    cycle_limit = 40 * row_name.size() + 100;
    // ready stays low through the flush sweep after reset
    @(posedge rst_n);
    low_cycles = 0;
    @(negedge clk);
    while (!ready) begin
      low_cycles++;
      @(negedge clk);
    end
    check_value("reset", "cycles with ready low", 16, low_cycles);
    check_value("reset", "bus reads", 0, wb_adrs.size());
    for (int i = 0; i < row_name.size(); i++) begin
      run_row(i);
    end
    repeat (2) @(posedge clk);
    print_counts();
    if (err_cnt == 0 && icache_top_inst.icache_checker_inst.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/tb_clkgen.sv ====
// clock and reset source for the testbench
// 100 ns clock period, active-low reset held for 10 cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  // half period of the 100 ns clock
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset released on a rising edge, after 10 cycles
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== bench/wb_mem_model.sv ====
// Wishbone classic slave memory model for the testbench
// returns an address-derived word for every read
// ack delay of 0 to 3 cycles from a seeded random stream

`timescale 1ns/1ps
`default_nettype none

module wb_mem_model (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            cyc_i,
  input  logic                            stb_i,
  input  logic [icache_pkg::ADDR_W-1:0]   adr_i,
  output logic [icache_pkg::WORD_W-1:0]   dat_o,
  output logic                            ack_o
);

  initial begin
    int unsigned                   delay;
    logic [icache_pkg::ADDR_W-1:0] adr_q;
    dat_o = '0;
    ack_o = 1'b0;
    void'($urandom(7203));
    forever begin
      // bus request seen where the master outputs are stable
      @(negedge clk_i);
      if (rst_ni && cyc_i && stb_i) begin
        adr_q = adr_i;
        delay = $urandom % 4;
        repeat (delay) @(negedge clk_i);
        @(posedge clk_i);
        // word address xor fixed pattern
        dat_o <= {adr_q[icache_pkg::ADDR_W-1:2], 2'b00} ^ 32'hA5A5_0000;
        ack_o <= 1'b1;
        @(posedge clk_i);
        ack_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/icache_ctrl.sv ====
// control FSM of the instruction cache
// flush sweep, lookup, line refill and uncached read sequencing
// Wishbone classic master for single-word reads
// response word capture and output data select

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                en_i,
  input  logic                                flush_i,
  input  logic                                req_i,
  input  logic [icache_pkg::ADDR_W-1:0]       addr_i,
  input  logic                                hit_i,
  input  logic [icache_pkg::WORD_W-1:0]       hit_word_i,
  input  logic                                victim_way_i,
  input  logic [icache_pkg::WORD_W-1:0]       wb_dat_i,
  input  logic                                wb_ack_i,
  output logic                                ready_o,
  output logic                                valid_o,
  output logic [icache_pkg::WORD_W-1:0]       data_o,
  output logic                                miss_o,
  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic [icache_pkg::ADDR_W-1:0]       wb_adr_o,
  output logic                                rd_en_o,
  output logic [icache_pkg::INDEX_W-1:0]      rd_index_o,
  output logic [icache_pkg::WORD_SEL_W-1:0]   rd_sel_o,
  output logic [icache_pkg::TAG_W-1:0]        rd_tag_o,
  output logic                                wr_en_o,
  output logic                                wr_way_o,
  output logic [icache_pkg::INDEX_W-1:0]      wr_index_o,
  output logic [icache_pkg::WORD_SEL_W-1:0]   wr_sel_o,
  output logic [icache_pkg::WORD_W-1:0]       wr_word_o,
  output logic                                flush_clr_o,
  output logic [icache_pkg::INDEX_W-1:0]      flush_idx_o,
  output logic                                victim_capture_o,
  output logic                                refill_done_o
);

  icache_pkg::ctrl_state_e                state_d, state_q;
  logic [icache_pkg::ADDR_W-1:0]          addr_q;
  logic                                   cache_en_d, cache_en_q;
  // pending flush request
  logic                                   flush_d, flush_q;
  logic [icache_pkg::INDEX_W-1:0]         flush_cnt_q;
  logic [icache_pkg::WORD_SEL_W-1:0]      word_cnt_q;
  // forces one idle bus cycle after each ack
  logic                                   gap_q;
  logic                                   bus_ack;
  logic                                   last_word;
  logic                                   hit_valid;
  // pulse for a refill or uncached response
  logic                                   resp_q;
  logic [icache_pkg::WORD_W-1:0]          word_q;

  ////////////////////////////////////////
  // address split and array requests
  ////////////////////////////////////////

  // index and word select go out with the request, the array read is registered
  assign rd_index_o = addr_i[icache_pkg::IDX_LSB +: icache_pkg::INDEX_W];
  assign rd_sel_o   = addr_i[icache_pkg::SEL_LSB +: icache_pkg::WORD_SEL_W];
  // tag of the latched request, compared one cycle later
  assign rd_tag_o   = addr_q[icache_pkg::ADDR_W-1:icache_pkg::TAG_LSB];

  assign wb_cyc_o  = ((state_q == icache_pkg::REFILL) || (state_q == icache_pkg::UNCACHED)) &&
                     !gap_q;
  assign wb_stb_o  = wb_cyc_o;
  assign bus_ack   = wb_cyc_o & wb_ack_i;
  assign last_word = (word_cnt_q == icache_pkg::WORD_SEL_W'(icache_pkg::LINE_WORDS - 1));

  // refill walks the line in ascending order, uncached reads its own word
  assign wb_adr_o = (state_q == icache_pkg::REFILL) ?
                    {addr_q[icache_pkg::ADDR_W-1:icache_pkg::IDX_LSB], word_cnt_q, 2'b00} :
                    {addr_q[icache_pkg::ADDR_W-1:icache_pkg::SEL_LSB], 2'b00};

  // refill words go straight into the victim way
  assign wr_en_o     = (state_q == icache_pkg::REFILL) && bus_ack;
  assign wr_way_o    = victim_way_i;
  assign wr_index_o  = addr_q[icache_pkg::IDX_LSB +: icache_pkg::INDEX_W];
  assign wr_sel_o    = word_cnt_q;
  assign wr_word_o   = wb_dat_i;
  assign flush_clr_o = (state_q == icache_pkg::FLUSH);
  assign flush_idx_o = flush_cnt_q;

  assign valid_o = hit_valid | resp_q;
  assign data_o  = (state_q == icache_pkg::LOOKUP) ? hit_word_i : word_q;

  ////////////////////////////////////////
  // next state logic
  ////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    // disabling takes effect at once, enabling goes through a flush
    cache_en_d       = cache_en_q & en_i;
    flush_d          = flush_q | flush_i;
    ready_o          = 1'b0;
    hit_valid        = 1'b0;
    miss_o           = 1'b0;
    victim_capture_o = 1'b0;
    refill_done_o    = 1'b0;
    rd_en_o          = 1'b0;
    unique case (state_q)
      icache_pkg::FLUSH: begin
        if (flush_cnt_q == icache_pkg::INDEX_W'(icache_pkg::NUM_SETS - 1)) begin
          state_d    = icache_pkg::IDLE;
          flush_d    = flush_i;
          cache_en_d = en_i;
        end
      end
      icache_pkg::IDLE: begin
        if (flush_q || (en_i && !cache_en_q)) begin
          state_d = icache_pkg::FLUSH;
        end else begin
          ready_o = 1'b1;
        end
      end
      icache_pkg::LOOKUP: begin
        if (hit_i) begin
          hit_valid = 1'b1;
          state_d   = icache_pkg::IDLE;
          // back-to-back hits unless a flush waits
          ready_o   = !flush_q && !(en_i && !cache_en_q);
        end else begin
          miss_o           = 1'b1;
          victim_capture_o = 1'b1;
          state_d          = icache_pkg::REFILL;
        end
      end
      icache_pkg::REFILL: begin
        if (bus_ack && last_word) begin
          refill_done_o = 1'b1;
          state_d       = icache_pkg::IDLE;
        end
      end
      icache_pkg::UNCACHED: begin
        if (bus_ack) begin
          state_d = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::FLUSH;
      end
    endcase
    // accepted request, disabled cache bypasses the arrays
    if (ready_o && req_i) begin
      rd_en_o = cache_en_q;
      state_d = cache_en_q ? icache_pkg::LOOKUP : icache_pkg::UNCACHED;
    end
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= icache_pkg::FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      word_cnt_q  <= '0;
      gap_q       <= 1'b0;
      resp_q      <= 1'b0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      gap_q      <= bus_ack;
      resp_q     <= refill_done_o | ((state_q == icache_pkg::UNCACHED) && bus_ack);
      // sweep counter wraps back to zero after the last set
      if (flush_clr_o) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
      if (victim_capture_o) begin
        word_cnt_q <= '0;
      end else if (wr_en_o) begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
    end
  end

  // request address and response word
  always_ff @(posedge clk_i) begin
    if (ready_o && req_i) begin
      addr_q <= addr_i;
    end
    // keep the requested word as it passes by during the refill
    if (wr_en_o && (word_cnt_q == addr_q[icache_pkg::SEL_LSB +: icache_pkg::WORD_SEL_W])) begin
      word_q <= wb_dat_i;
    end else if ((state_q == icache_pkg::UNCACHED) && bus_ack) begin
      word_q <= wb_dat_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/icache_pkg.sv ====
// shared definitions of the instruction cache
// address split widths, cache geometry, replacement LFSR width
// and the controller state encoding

`default_nettype none

package icache_pkg;

  ////////////////////////////////////////
  // word and address widths
  ////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  ////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////

  localparam int LINE_WORDS = 4;
  localparam int WORD_SEL_W = 2;
  localparam int NUM_SETS   = 16;
  localparam int INDEX_W    = 4;
  // address bits minus index, word select and the two byte bits
  localparam int TAG_W      = 24;
  localparam int NUM_WAYS   = 2;

  // bit positions of the address fields
  localparam int SEL_LSB = 2;
  localparam int IDX_LSB = SEL_LSB + WORD_SEL_W;
  localparam int TAG_LSB = IDX_LSB + INDEX_W;

  // replacement
  localparam int LFSR_W = 8;

  // controller FSM states, FLUSH is the reset state
  typedef enum logic [2:0] {
    FLUSH,
    IDLE,
    LOOKUP,
    REFILL,
    UNCACHED
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== rtl/icache_repl.sv ====
// victim way selection for line refills
// lowest invalid way first, else a pseudo-random way from an 8-bit LFSR

`timescale 1ns/1ps
`default_nettype none

module icache_repl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [icache_pkg::NUM_WAYS-1:0]   way_valid_i,
  input  logic                              capture_i,
  input  logic                              step_i,
  output logic                              victim_way_o
);

  logic [icache_pkg::LFSR_W-1:0] lfsr_q;
  logic                          feedback;
  logic                          victim_d, victim_q;
  // set was full at lookup time
  logic                          all_valid_q;

  assign victim_d = !way_valid_i[0] ? 1'b0 :
                    !way_valid_i[1] ? 1'b1 :
                                      lfsr_q[0];

  // taps 8,6,5,4 give a maximal length sequence
  assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q      <= icache_pkg::LFSR_W'(1);
      victim_q    <= 1'b0;
      all_valid_q <= 1'b0;
    end else begin
      // choice held from lookup until the refill ends
      if (capture_i) begin
        victim_q    <= victim_d;
        all_valid_q <= &way_valid_i;
      end
      if (step_i && all_valid_q) begin
        lfsr_q <= {lfsr_q[icache_pkg::LFSR_W-2:0], feedback};
      end
    end
  end

  assign victim_way_o = victim_q;

endmodule

`default_nettype wire

// ==== rtl/icache_top.sv ====
// top level of the two-way instruction cache
// fetch port, Wishbone classic refill port
// controller, way arrays and replacement selector

`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            en_i,
  input  logic                            flush_i,
  input  logic                            req_i,
  input  logic [icache_pkg::ADDR_W-1:0]   addr_i,
  output logic                            ready_o,
  output logic                            valid_o,
  output logic [icache_pkg::WORD_W-1:0]   data_o,
  output logic                            miss_o,
  output logic                            wb_cyc_o,
  output logic                            wb_stb_o,
  output logic [icache_pkg::ADDR_W-1:0]   wb_adr_o,
  input  logic [icache_pkg::WORD_W-1:0]   wb_dat_i,
  input  logic                            wb_ack_i
);

  // array read side
  logic                                 rd_en;
  logic [icache_pkg::INDEX_W-1:0]       rd_index;
  logic [icache_pkg::WORD_SEL_W-1:0]    rd_sel;
  logic [icache_pkg::TAG_W-1:0]         rd_tag;
  logic                                 hit;
  logic [icache_pkg::WORD_W-1:0]        hit_word;
  logic [icache_pkg::NUM_WAYS-1:0]      way_valid;
  // array write side
  logic                                 wr_en;
  logic                                 wr_way;
  logic [icache_pkg::INDEX_W-1:0]       wr_index;
  logic [icache_pkg::WORD_SEL_W-1:0]    wr_sel;
  logic [icache_pkg::WORD_W-1:0]        wr_word;
  logic                                 flush_clr;
  logic [icache_pkg::INDEX_W-1:0]       flush_idx;
  // replacement
  logic                                 victim_way;
  logic                                 victim_capture;
  logic                                 refill_done;

  icache_ctrl icache_ctrl_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .en_i             (en_i),
    .flush_i          (flush_i),
    .req_i            (req_i),
    .addr_i           (addr_i),
    .hit_i            (hit),
    .hit_word_i       (hit_word),
    .victim_way_i     (victim_way),
    .wb_dat_i         (wb_dat_i),
    .wb_ack_i         (wb_ack_i),
    .ready_o          (ready_o),
    .valid_o          (valid_o),
    .data_o           (data_o),
    .miss_o           (miss_o),
    .wb_cyc_o         (wb_cyc_o),
    .wb_stb_o         (wb_stb_o),
    .wb_adr_o         (wb_adr_o),
    .rd_en_o          (rd_en),
    .rd_index_o       (rd_index),
    .rd_sel_o         (rd_sel),
    .rd_tag_o         (rd_tag),
    .wr_en_o          (wr_en),
    .wr_way_o         (wr_way),
    .wr_index_o       (wr_index),
    .wr_sel_o         (wr_sel),
    .wr_word_o        (wr_word),
    .flush_clr_o      (flush_clr),
    .flush_idx_o      (flush_idx),
    .victim_capture_o (victim_capture),
    .refill_done_o    (refill_done)
  );

  icache_ways icache_ways_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_en_i     (rd_en),
    .rd_index_i  (rd_index),
    .rd_sel_i    (rd_sel),
    .rd_tag_i    (rd_tag),
    .wr_en_i     (wr_en),
    .wr_way_i    (wr_way),
    .wr_index_i  (wr_index),
    .wr_sel_i    (wr_sel),
    .wr_word_i   (wr_word),
    .flush_clr_i (flush_clr),
    .flush_idx_i (flush_idx),
    .hit_o       (hit),
    .hit_word_o  (hit_word),
    .way_valid_o (way_valid)
  );

  icache_repl icache_repl_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .way_valid_i  (way_valid),
    .capture_i    (victim_capture),
    .step_i       (refill_done),
    .victim_way_o (victim_way)
  );

endmodule

`default_nettype wire

// ==== rtl/icache_ways.sv ====
// tag, valid and data arrays of both cache ways
// registered read of the indexed set
// tag compare and hit word select
// refill write and per-set valid clear for the flush sweep

`timescale 1ns/1ps
`default_nettype none

module icache_ways (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                rd_en_i,
  input  logic [icache_pkg::INDEX_W-1:0]      rd_index_i,
  input  logic [icache_pkg::WORD_SEL_W-1:0]   rd_sel_i,
  input  logic [icache_pkg::TAG_W-1:0]        rd_tag_i,
  input  logic                                wr_en_i,
  input  logic                                wr_way_i,
  input  logic [icache_pkg::INDEX_W-1:0]      wr_index_i,
  input  logic [icache_pkg::WORD_SEL_W-1:0]   wr_sel_i,
  input  logic [icache_pkg::WORD_W-1:0]       wr_word_i,
  input  logic                                flush_clr_i,
  input  logic [icache_pkg::INDEX_W-1:0]      flush_idx_i,
  output logic                                hit_o,
  output logic [icache_pkg::WORD_W-1:0]       hit_word_o,
  output logic [icache_pkg::NUM_WAYS-1:0]     way_valid_o
);

  // per-way compare result
  logic [icache_pkg::NUM_WAYS-1:0]   hit_way;
  // selected word of each way from the registered read
  logic [icache_pkg::WORD_W-1:0]     way_word [icache_pkg::NUM_WAYS];

  for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : gen_way
    logic [icache_pkg::TAG_W-1:0]    tag_mem  [icache_pkg::NUM_SETS];
    // line words are stored flat, addressed by {index, word select}
    logic [icache_pkg::WORD_W-1:0]   data_mem [icache_pkg::NUM_SETS * icache_pkg::LINE_WORDS];
    logic [icache_pkg::NUM_SETS-1:0] valid_q;
    logic [icache_pkg::TAG_W-1:0]    rd_tag_q;
    logic [icache_pkg::WORD_W-1:0]   rd_word_q;
    logic                            rd_vld_q;
    logic                            way_we;
    // first word of a refill opens the line
    logic                            line_open;

    assign way_we    = wr_en_i && (wr_way_i == 1'(w));
    assign line_open = way_we && (wr_sel_i == '0);

    ////////////////////////////////////////
    // tag and data arrays
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
      if (way_we) begin
        data_mem[{wr_index_i, wr_sel_i}] <= wr_word_i;
      end
      // rd_tag_i still holds the missing request's tag during the refill
      if (line_open) begin
        tag_mem[wr_index_i] <= rd_tag_i;
      end
      if (rd_en_i) begin
        rd_tag_q  <= tag_mem[rd_index_i];
        rd_word_q <= data_mem[{rd_index_i, rd_sel_i}];
      end
    end

    // valid bits and their registered read
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q  <= '0;
        rd_vld_q <= 1'b0;
      end else begin
        if (flush_clr_i) begin
          valid_q[flush_idx_i] <= 1'b0;
        end else if (line_open) begin
          valid_q[wr_index_i] <= 1'b1;
        end
        if (rd_en_i) begin
          rd_vld_q <= valid_q[rd_index_i];
        end
      end
    end

    assign hit_way[w]     = rd_vld_q && (rd_tag_q == rd_tag_i);
    assign way_word[w]    = rd_word_q;
    assign way_valid_o[w] = rd_vld_q;
  end

  ////////////////////////////////////////
  // hit word select
  ////////////////////////////////////////

  assign hit_o = |hit_way;

  // and-or mux, at most one way hits
  always_comb begin
    hit_word_o = '0;
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      hit_word_o = hit_word_o | (way_word[w] & {icache_pkg::WORD_W{hit_way[w]}});
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/icache_pkg.sv
rtl/icache_repl.sv
rtl/icache_ways.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
bench/tb_clkgen.sv
bench/wb_mem_model.sv
bench/icache_checker.sv
bench/icache_tb.sv
